// File: fod_pkg.sv
`default_nettype none

package fod_pkg;

	// --------------------------------------------------
	// word widths
	// --------------------------------------------------
	// integer part of the frequency word
	localparam int W_INT = 6;
	// fractional part of the frequency word
	localparam int W_FRAC = 16;
	localparam int W_FCW = W_INT + W_FRAC;
	localparam int W_DTC = 10;
	localparam int W_MMD = 6;
	// full gain product before rounding
	localparam int W_PROD = W_DTC + W_FRAC;

	// depth of the reset and reference synchronizers
	localparam int SYNC_STAGES = 3;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------
	// integer above fraction
	typedef logic [W_FCW-1:0] fcw_t;
	// unsigned, 0 <= x < 1
	typedef logic [W_FRAC-1:0] frac_t;
	typedef logic [W_MMD-1:0] mmd_t;
	typedef logic [W_DTC-1:0] dtc_t;
	typedef logic [W_PROD-1:0] prod_t;

	// static dtc setup
	typedef struct packed {
		logic rt_en;
		dtc_t gain;
		dtc_t ofst;
	} dtc_cfg_t;

	// one lane of divider control words
	typedef struct packed {
		mmd_t mmd;
		logic rt;
		dtc_t dtc;
	} dcw_lane_t;

	// reset values
	localparam mmd_t MMD_RESET = 6'd4;
	localparam fcw_t FCW_RESET = '0;

endpackage

`default_nettype wire

// File: fod_reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fod_reset_gen (
	input  logic CLK,
	input  logic NRST,
	input  logic sys_ref,
	input  logic sys_en,
	output logic nrst_sync,
	output logic sync_pulse
);
	import fod_pkg::*;

	// reset shift register
	logic [SYNC_STAGES-1:0] rst_q;
	// reference chain plus one flop for the edge compare
	logic [SYNC_STAGES:0] ref_q;
	logic ref_rise;
	// saturating count of reference edges
	logic [2:0] edge_cnt;

	// --------------------------------------------------
	// reset synchronizer
	// --------------------------------------------------
	// async assert, release after SYNC_STAGES edges
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			rst_q <= '0;
		end else begin
			rst_q <= {rst_q[SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign nrst_sync = rst_q[SYNC_STAGES-1];

	// --------------------------------------------------
	// system reference sync
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			ref_q <= '0;
		end else begin
			ref_q <= {ref_q[SYNC_STAGES-1:0], sys_ref};
		end
	end

	// rising edge from the last two flops
	assign ref_rise = ref_q[SYNC_STAGES-1] & ~ref_q[SYNC_STAGES];

	// only the first edge of each enable period fires
	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			edge_cnt <= '0;
			sync_pulse <= 1'b0;
		end else begin
			if (!sys_en) begin
				edge_cnt <= '0;
			end else if (ref_rise && edge_cnt != 3'd7) begin
				edge_cnt <= edge_cnt + 3'd1;
			end
			sync_pulse <= sys_en & ref_rise & (edge_cnt == 3'd0);
		end
	end

	// one-shot pulse
	a_pulse_single: assert property (@(posedge CLK) disable iff (!nrst_sync)
		sync_pulse |=> !sync_pulse);

endmodule

`default_nettype wire

// File: fod_word_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fod_word_gen #(
	parameter int N_LANES = 4
) (
	input  logic                         CLK,
	input  logic                         nrst_sync,
	input  logic                         freq_hop,
	input  fod_pkg::fcw_t                fcw,
	input  logic [N_LANES-1:0]           dsm_car,
	input  fod_pkg::frac_t [N_LANES-1:0] dsm_phe,
	input  logic                         rt_en,
	output fod_pkg::frac_t               fcw_frac,
	output fod_pkg::mmd_t [N_LANES-1:0]  mmd,
	output logic [N_LANES-1:0]           rt
);
	import fod_pkg::*;

	// frequency word in use
	fcw_t hop_q;
	logic [W_INT-1:0] hop_int;
	// mmd pipeline
	mmd_t [N_LANES-1:0] mmd_d1;
	mmd_t [N_LANES-1:0] mmd_d2;
	// retimer pipeline
	logic [N_LANES-1:0] rt_d1;
	logic [N_LANES-1:0] rt_d2;
	logic [N_LANES-1:0] phe_half;

	// --------------------------------------------------
	// frequency hop register
	// --------------------------------------------------
	// new word only takes effect on a hop strobe
	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			hop_q <= FCW_RESET;
		end else if (freq_hop) begin
			hop_q <= fcw;
		end
	end

	assign hop_int = hop_q[W_FCW-1:W_FRAC];
	assign fcw_frac = hop_q[W_FRAC-1:0];

	// half-period select per lane
	always_comb begin
		for (int i = 0; i < N_LANES; i++) begin
			phe_half[i] = rt_en & dsm_phe[i][W_FRAC-1];
		end
	end

	// --------------------------------------------------
	// mmd and rt words, 3 stages
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			mmd_d1 <= {N_LANES{MMD_RESET}};
			mmd_d2 <= {N_LANES{MMD_RESET}};
			mmd <= {N_LANES{MMD_RESET}};
			rt_d1 <= '0;
			rt_d2 <= '0;
			rt <= '0;
		end else begin
			// divide by integer, plus one on carry
			for (int i = 0; i < N_LANES; i++) begin
				mmd_d1[i] <= mmd_t'(hop_int) + mmd_t'(dsm_car[i]);
			end
			mmd_d2 <= mmd_d1;
			mmd <= mmd_d2;
			rt_d1 <= phe_half;
			rt_d2 <= rt_d1;
			rt <= rt_d2;
		end
	end

	// retimer stays off once disabled long enough
	a_rt_off: assert property (@(posedge CLK) disable iff (!nrst_sync)
		(!rt_en)[*4] |-> ##3 (rt == '0));

endmodule

`default_nettype wire

// File: fod_dsm_mash1.sv
`timescale 1ns/1ps
`default_nettype none

module fod_dsm_mash1 #(
	parameter int N_LANES = 4
) (
	input  logic                         CLK,
	input  logic                         nrst_sync,
	input  logic                         dsm_en,
	input  logic                         sync_pulse,
	input  logic                         dsm_sync_en,
	input  fod_pkg::frac_t               fcw_frac,
	output logic [N_LANES-1:0]           dsm_car,
	output fod_pkg::frac_t [N_LANES-1:0] dsm_phe
);
	import fod_pkg::*;

	// last lane sum, start point of the next cycle
	frac_t acc_q;
	logic [N_LANES-1:0] car_nxt;
	frac_t [N_LANES-1:0] phe_nxt;
	logic sync_clr;

	// phase sync restarts the modulator
	assign sync_clr = sync_pulse & dsm_sync_en;

	// --------------------------------------------------
	// lane adder chain
	// --------------------------------------------------
	// lane 0 starts from the stored sum
	// each later lane from the lane before it
	always_comb begin
		frac_t prev;
		logic [W_FRAC:0] sum;
		prev = acc_q;
		for (int i = 0; i < N_LANES; i++) begin
			sum = {1'b0, prev} + {1'b0, fcw_frac};
			// overflow is the carry
			car_nxt[i] = sum[W_FRAC];
			// residue stays below one
			phe_nxt[i] = sum[W_FRAC-1:0];
			prev = sum[W_FRAC-1:0];
		end
	end

	// --------------------------------------------------
	// output and accumulator registers
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			dsm_car <= '0;
			dsm_phe <= '0;
			acc_q <= '0;
		end else if (dsm_en) begin
			if (sync_clr) begin
				dsm_car <= '0;
				dsm_phe <= '0;
				acc_q <= '0;
			end else begin
				dsm_car <= car_nxt;
				dsm_phe <= phe_nxt;
				acc_q <= phe_nxt[N_LANES-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: fod_dtc_map.sv
`timescale 1ns/1ps
`default_nettype none

module fod_dtc_map #(
	parameter int N_LANES = 4
) (
	input  logic                         CLK,
	input  logic                         nrst_sync,
	input  fod_pkg::frac_t [N_LANES-1:0] dsm_phe,
	input  fod_pkg::dtc_cfg_t            dtc_cfg,
	output fod_pkg::dtc_t [N_LANES-1:0]  dtc
);
	import fod_pkg::*;

	// stage 1, split fraction and half-period bit
	frac_t [N_LANES-1:0] frac_s1;
	logic [N_LANES-1:0] rt_s1;
	dtc_t gain_s1;
	dtc_t ofst_s1;
	// stage 2, gain product
	prod_t [N_LANES-1:0] prod_s2;
	logic [N_LANES-1:0] rt_s2;
	dtc_t ofst_s2;
	// stage 3 input
	dtc_t [N_LANES-1:0] code_nxt;

	// --------------------------------------------------
	// stage 1
	// --------------------------------------------------
	// with retimer on the top bit goes to rt
	// and the rest is rescaled to a full period
	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			frac_s1 <= '0;
			rt_s1 <= '0;
			gain_s1 <= '0;
			ofst_s1 <= '0;
		end else begin
			for (int i = 0; i < N_LANES; i++) begin
				if (dtc_cfg.rt_en) begin
					frac_s1[i] <= {dsm_phe[i][W_FRAC-2:0], 1'b0};
					rt_s1[i] <= dsm_phe[i][W_FRAC-1];
				end else begin
					frac_s1[i] <= dsm_phe[i];
					rt_s1[i] <= 1'b0;
				end
			end
			// config travels with the data
			gain_s1 <= dtc_cfg.gain;
			ofst_s1 <= dtc_cfg.ofst;
		end
	end

	// --------------------------------------------------
	// stage 2 and 3
	// --------------------------------------------------
	// round half up on bit W_FRAC-1, then offset
	always_comb begin
		for (int i = 0; i < N_LANES; i++) begin
			code_nxt[i] = prod_s2[i][W_PROD-1:W_FRAC] + dtc_t'(prod_s2[i][W_FRAC-1])
				+ (rt_s2[i] ? ofst_s2 : dtc_t'(0));
		end
	end

	always_ff @(posedge CLK or negedge nrst_sync) begin
		if (!nrst_sync) begin
			prod_s2 <= '0;
			rt_s2 <= '0;
			ofst_s2 <= '0;
			dtc <= '0;
		end else begin
			// codes per period times fraction
			for (int i = 0; i < N_LANES; i++) begin
				prod_s2[i] <= prod_t'(gain_s1) * prod_t'(frac_s1[i]);
			end
			rt_s2 <= rt_s1;
			ofst_s2 <= ofst_s1;
			dtc <= code_nxt;
		end
	end

	// no rescale without retimer
	for (genvar g = 0; g < N_LANES; g++) begin : g_chk
		a_frac_pass: assert property (@(posedge CLK) disable iff (!nrst_sync)
			!dtc_cfg.rt_en |=> frac_s1[g] == $past(dsm_phe[g]));
	end

endmodule

`default_nettype wire

// File: fod_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fod_ctrl #(
	parameter int N_LANES = 4
) (
	input  logic                            CLK,
	input  logic                            NRST,
	input  logic                            sys_ref,
	input  logic                            sys_en,
	input  logic                            dsm_en,
	input  logic                            dsm_sync_en,
	input  logic                            freq_hop,
	input  fod_pkg::fcw_t                   fcw,
	input  fod_pkg::dtc_cfg_t               dtc_cfg,
	output fod_pkg::dcw_lane_t [N_LANES-1:0] dcw
);
	import fod_pkg::*;

	logic nrst_sync;
	logic sync_pulse;
	// hop word fraction into the modulator
	frac_t fcw_frac;
	// modulator outputs
	logic [N_LANES-1:0] dsm_car;
	frac_t [N_LANES-1:0] dsm_phe;
	// aligned lane words
	mmd_t [N_LANES-1:0] mmd;
	logic [N_LANES-1:0] rt;
	dtc_t [N_LANES-1:0] dtc;

	// --------------------------------------------------
	// reset and phase sync
	// --------------------------------------------------
	fod_reset_gen u_reset_gen (
		.CLK        (CLK),
		.NRST       (NRST),
		.sys_ref    (sys_ref),
		.sys_en     (sys_en),
		.nrst_sync  (nrst_sync),
		.sync_pulse (sync_pulse)
	);

	// --------------------------------------------------
	// word path
	// --------------------------------------------------
	// hop register and mmd/rt pipelines
	fod_word_gen #(.N_LANES(N_LANES)) u_word_gen (
		.CLK       (CLK),
		.nrst_sync (nrst_sync),
		.freq_hop  (freq_hop),
		.fcw       (fcw),
		.dsm_car   (dsm_car),
		.dsm_phe   (dsm_phe),
		.rt_en     (dtc_cfg.rt_en),
		.fcw_frac  (fcw_frac),
		.mmd       (mmd),
		.rt        (rt)
	);

	fod_dsm_mash1 #(.N_LANES(N_LANES)) u_dsm (
		.CLK         (CLK),
		.nrst_sync   (nrst_sync),
		.dsm_en      (dsm_en),
		.sync_pulse  (sync_pulse),
		.dsm_sync_en (dsm_sync_en),
		.fcw_frac    (fcw_frac),
		.dsm_car     (dsm_car),
		.dsm_phe     (dsm_phe)
	);

	// residue to dtc code, same 3 stage latency as mmd
	fod_dtc_map #(.N_LANES(N_LANES)) u_dtc_map (
		.CLK       (CLK),
		.nrst_sync (nrst_sync),
		.dsm_phe   (dsm_phe),
		.dtc_cfg   (dtc_cfg),
		.dtc       (dtc)
	);

	// pack per lane
	for (genvar g = 0; g < N_LANES; g++) begin : g_pack
		assign dcw[g] = '{mmd: mmd[g], rt: rt[g], dtc: dtc[g]};
	end

endmodule

`default_nettype wire

// File: fod_ctrl_tb_ref.svh
`ifndef FOD_CTRL_TB_REF_SVH
`define FOD_CTRL_TB_REF_SVH

// --------------------------------------------------
// random numbers
// --------------------------------------------------
// 32-bit lcg, full period constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// --------------------------------------------------
// modulator model
// --------------------------------------------------
// one clock of the lane chain
// running sum kept as a plain integer, carry when it reaches one
function automatic void dsm_step(
	input  frac_t                acc_in,
	input  frac_t                f,
	output logic [N_LANES-1:0]   car,
	output frac_t [N_LANES-1:0]  phe,
	output frac_t                acc_out
);
	int unsigned s;
	s = 32'(acc_in);
	for (int i = 0; i < N_LANES; i++) begin
		s = s + 32'(f);
		car[i] = (s >= 32'd65536);
		s = s % 32'd65536;
		phe[i] = frac_t'(s);
	end
	// last lane seeds lane 0 next time
	acc_out = frac_t'(s);
endfunction

// --------------------------------------------------
// lane word mapping
// --------------------------------------------------
function automatic dcw_lane_t lane_word(
	input fcw_t     hop,
	input logic     car,
	input frac_t    phe,
	input dtc_cfg_t cfg
);
	dcw_lane_t w;
	int unsigned fr;
	int unsigned code;
	// integer part plus carry, wraps at 64
	w.mmd = mmd_t'((32'(hop[W_FCW-1:W_FRAC]) + 32'(car)) % 32'd64);
	if (cfg.rt_en) begin
		// top half of the period goes to the retimer
		w.rt = phe[W_FRAC-1];
		fr = (32'(phe) * 32'd2) % 32'd65536;
	end else begin
		w.rt = 1'b0;
		fr = 32'(phe);
	end
	// gain times fraction over 65536, half up
	code = (32'(cfg.gain) * fr + 32'd32768) / 32'd65536;
	if (w.rt) begin
		code = code + 32'(cfg.ofst);
	end
	w.dtc = dtc_t'(code % 32'd1024);
	return w;
endfunction

`endif

// File: fod_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fod_ctrl_tb;
	import fod_pkg::*;

	localparam int N_LANES = 4;
	localparam int T_PERIOD = 10;
	// test lengths in cycles
	localparam int LEN_RESET = 10;
	localparam int LEN_CARRY = 30;
	localparam int LEN_RAND = 8 * 26;
	localparam int LEN_HOP = 40;
	localparam int LEN_SYNC = 80;
	localparam int WATCHDOG_NS =
		(LEN_RESET + LEN_CARRY + LEN_RAND + LEN_HOP + LEN_SYNC + 100) * T_PERIOD;

	typedef dcw_lane_t [N_LANES-1:0] dcw_vec_t;
	localparam dcw_lane_t RST_WORD = '{mmd: 6'd4, rt: 1'b0, dtc: 10'd0};
	localparam dcw_vec_t RST_VEC = {N_LANES{RST_WORD}};

	logic CLK;
	logic NRST;
	logic sys_ref;
	logic sys_en;
	logic dsm_en;
	logic dsm_sync_en;
	logic freq_hop;
	fcw_t fcw;
	dtc_cfg_t dtc_cfg;
	dcw_vec_t dcw;

	// model of hop register, modulator and sync
	fcw_t m_hop;
	frac_t m_acc;
	logic [N_LANES-1:0] m_car;
	frac_t [N_LANES-1:0] m_phe;
	logic m_sync;
	logic [3:0] m_ref;
	// set once the enable period has had its restart
	logic m_fired;
	int rst_cnt = 0;
	int n_sync = 0;
	// queue head is the word dcw shows now
	dcw_vec_t exp_q[$];
	logic model_on = 1'b0;

	int n_checks;
	int n_errors;
	int test_err0;
	logic [31:0] seed;

	`include "fod_ctrl_tb_ref.svh"

	fod_ctrl #(.N_LANES(N_LANES)) dut (
		.CLK         (CLK),
		.NRST        (NRST),
		.sys_ref     (sys_ref),
		.sys_en      (sys_en),
		.dsm_en      (dsm_en),
		.dsm_sync_en (dsm_sync_en),
		.freq_hop    (freq_hop),
		.fcw         (fcw),
		.dtc_cfg     (dtc_cfg),
		.dcw         (dcw)
	);

	initial CLK = 1'b0;
	always #(T_PERIOD / 2) CLK = ~CLK;

	// --------------------------------------------------
	// reference model, one step per rising edge
	// --------------------------------------------------
	always @(posedge CLK) begin
		dcw_vec_t w;
		logic rise;
		if (!NRST || rst_cnt < 3) begin
			// internal reset lasts 3 edges past NRST release
			if (!NRST) begin
				rst_cnt = 0;
			end else begin
				rst_cnt = rst_cnt + 1;
			end
			m_hop = '0;
			m_acc = '0;
			m_car = '0;
			m_phe = '0;
			m_sync = 1'b0;
			m_ref = '0;
			m_fired = 1'b0;
			exp_q.delete();
			repeat (3) exp_q.push_back(RST_VEC);
			model_on = 1'b1;
		end else begin
			// words from the modulator state before this edge
			for (int i = 0; i < N_LANES; i++) begin
				w[i] = lane_word(m_hop, m_car[i], m_phe[i], dtc_cfg);
			end
			exp_q.push_back(w);
			void'(exp_q.pop_front());
			if (dsm_en) begin
				if (m_sync && dsm_sync_en) begin
					m_car = '0;
					m_phe = '0;
					m_acc = '0;
				end else begin
					dsm_step(m_acc, m_hop[W_FRAC-1:0], m_car, m_phe, m_acc);
				end
			end
			// reference edge seen 3 flops late and pulsed one edge after
			rise = m_ref[2] & ~m_ref[3];
			m_sync = sys_en & rise & ~m_fired;
			if (m_sync) begin
				n_sync = n_sync + 1;
			end
			// only the first edge of an enable period restarts
			if (!sys_en) begin
				m_fired = 1'b0;
			end else if (m_sync) begin
				m_fired = 1'b1;
			end
			m_ref = {m_ref[2:0], sys_ref};
			if (freq_hop) begin
				m_hop = fcw;
			end
		end
	end

	// --------------------------------------------------
	// compare at mid cycle
	// --------------------------------------------------
	always @(negedge CLK) begin
		if (model_on) begin
			for (int i = 0; i < N_LANES; i++) begin
				n_checks++;
				if (dcw[i] !== exp_q[0][i]) begin
					n_errors++;
					$display("CHECK FAILED at %0t: lane %0d got %0d/%0d/%0d, want %0d/%0d/%0d",
						$time, i, dcw[i].mmd, dcw[i].rt, dcw[i].dtc,
						exp_q[0][i].mmd, exp_q[0][i].rt, exp_q[0][i].dtc);
				end
			end
		end
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	// lands 1 ns past a rising edge
	task automatic next_cycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	// one-cycle hop strobe
	task automatic hop_to(input fcw_t w);
		fcw = w;
		freq_hop = 1'b1;
		next_cycles(1);
		freq_hop = 1'b0;
	endtask

	task automatic end_test(input string name);
		if (n_errors == test_err0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, n_errors - test_err0);
		end
		test_err0 = n_errors;
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		int n_car;
		frac_t f;
		NRST = 1'b0;
		sys_ref = 1'b0;
		sys_en = 1'b0;
		dsm_en = 1'b0;
		dsm_sync_en = 1'b0;
		freq_hop = 1'b0;
		fcw = '0;
		dtc_cfg = '0;
		seed = 32'ha4b8;
		n_checks = 0;
		n_errors = 0;
		test_err0 = 0;

		// reset word until the pipeline sees the first real edge
		repeat (2) @(posedge CLK);
		#1;
		NRST = 1'b1;
		repeat (5) begin
			@(negedge CLK);
			for (int i = 0; i < N_LANES; i++) begin
				n_checks++;
				if (dcw[i] !== RST_WORD) begin
					n_errors++;
					$display("CHECK FAILED at %0t: lane %0d not at its reset word", $time, i);
				end
			end
		end
		next_cycles(LEN_RESET - 7);
		end_test("reset");

		// quarter fraction gives one carry per group of four lanes
		dtc_cfg = '{rt_en: 1'b0, gain: 10'd700, ofst: 10'd0};
		dsm_en = 1'b1;
		hop_to({6'd8, 16'h4000});
		next_cycles(6);
		repeat (LEN_CARRY - 7) begin
			@(negedge CLK);
			n_car = 0;
			for (int i = 0; i < N_LANES; i++) begin
				if (dcw[i].mmd == 6'd9) begin
					n_car++;
				end
			end
			n_checks++;
			if (n_car != 1) begin
				n_errors++;
				$display("CHECK FAILED at %0t: %0d carries in one lane group", $time, n_car);
			end
		end
		next_cycles(1);
		end_test("one carry");

		// random words and dtc setup with the retimer toggled per run
		for (int r = 0; r < 8; r++) begin
			seed = lcg_next(seed);
			f = frac_t'(seed[31:16]);
			seed = lcg_next(seed);
			dtc_cfg.rt_en = (r % 2 == 1);
			dtc_cfg.gain = dtc_t'(seed[31:22]);
			dtc_cfg.ofst = dtc_t'(seed[21:12]);
			hop_to({seed[11:6], f});
			next_cycles(25);
		end
		end_test("random");

		// hop and then a bus change with no strobe
		hop_to({6'd20, 16'h2aaa});
		next_cycles(15);
		fcw = {6'd33, 16'h7001};
		next_cycles(LEN_HOP - 16);
		end_test("hop");

		// phase sync fires once per enable period
		hop_to({6'd12, 16'h1357});
		sys_en = 1'b1;
		dsm_sync_en = 1'b1;
		next_cycles(10);
		sys_ref = 1'b1;
		next_cycles(10);
		sys_ref = 1'b0;
		next_cycles(10);
		// second edge in the same enable period
		sys_ref = 1'b1;
		next_cycles(10);
		sys_ref = 1'b0;
		sys_en = 1'b0;
		next_cycles(2);
		sys_en = 1'b1;
		next_cycles(5);
		sys_ref = 1'b1;
		next_cycles(10);
		sys_ref = 1'b0;
		next_cycles(10);
		// two enable periods with one restart each
		n_checks++;
		if (n_sync != 2) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %0d modulator restarts, expected 2", $time, n_sync);
		end
		end_test("sync");

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fod_ctrl.f
+incdir+.
fod_pkg.sv
fod_reset_gen.sv
fod_word_gen.sv
fod_dsm_mash1.sv
fod_dtc_map.sv
fod_ctrl.sv
fod_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the FOD control-word generator

VERILATOR  ?= verilator
FLIST      ?= fod_ctrl.f
TB_TOP     ?= fod_ctrl_tb
RTL_TOP    ?= fod_ctrl
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= ALL CHECKS PASSED

SRCS     := $(filter %.sv,$(shell cat $(FLIST)))
RTL_SRCS := $(filter-out $(TB_TOP).sv,$(SRCS))
HDRS     := $(wildcard *.svh)
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

# pass only when the testbench printed the pass message
run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
